// ==== flist.f ====
common/fetch_pkg.sv
verilog/fetch_sequencer.sv
icache/icache.sv
icache/apb_line_reader.sv
verilog/instr_predecoder.sv
verilog/fetch_top.sv
bench/apb_mem_model.sv
bench/fetch_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_top_tb \
    -Mdir obj_dir -f flist.f > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/Vfetch_top_tb > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

// ==== bench/fetch_top_tb.sv ====
`timescale 1ns/1ps

module fetch_top_tb;

    localparam int NUM_ROWS  = 8;
    localparam int MEM_WORDS = 1024;
    localparam int MAX_WALK  = 64;

    logic                  clk;
    logic                  rst;
    logic                  start;
    fetch_pkg::addr_t      start_pc;
    logic                  pready;
    fetch_pkg::word_t      prdata;
    logic                  pslverr;
    logic                  psel;
    logic                  penable;
    logic [31:0]           paddr;
    logic                  out_valid;
    fetch_pkg::instr_rec_t out_rec;
    logic                  busy;

    logic [3:0]            wait_states;
    logic                  err_en;
    fetch_pkg::addr_t      err_addr;

    // test table with up to three branches per row
    fetch_pkg::addr_t row_start  [NUM_ROWS];
    fetch_pkg::addr_t row_halt   [NUM_ROWS];
    int               row_nbr    [NUM_ROWS];
    fetch_pkg::addr_t row_br_pc  [NUM_ROWS][3];
    fetch_pkg::addr_t row_br_tgt [NUM_ROWS][3];
    logic             row_err_en [NUM_ROWS];
    fetch_pkg::addr_t row_err    [NUM_ROWS];
    logic [3:0]       row_waits  [NUM_ROWS];
    int               row_xfers  [NUM_ROWS];

    fetch_pkg::instr_rec_t exp_q [$];

    int errors      = 0;
    int checks      = 0;
    int xfer_count  = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    fetch_pkg::addr_t last_paddr;

    fetch_top #(
        .NUM_SETS   (64),
        .APB_ADDR_W (32)
    ) fetch_top_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .start_pc  (start_pc),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr),
        .out_valid (out_valid),
        .out_rec   (out_rec),
        .busy      (busy)
    );

    apb_mem_model mem_model_i (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .paddr       (paddr),
        .wait_states (wait_states),
        .err_en      (err_en),
        .err_addr    (err_addr),
        .pready      (pready),
        .prdata      (prdata),
        .pslverr     (pslverr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!rst && psel && penable && pready) begin
            xfer_count <= xfer_count + 1;
            last_paddr <= paddr;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic set_row(input int r, input fetch_pkg::addr_t start_a,
                           input fetch_pkg::addr_t halt_a, input int nbr,
                           input fetch_pkg::addr_t b0, input fetch_pkg::addr_t t0,
                           input fetch_pkg::addr_t b1, input fetch_pkg::addr_t t1,
                           input fetch_pkg::addr_t b2, input fetch_pkg::addr_t t2,
                           input logic e_en, input fetch_pkg::addr_t e_addr,
                           input logic [3:0] waits, input int xfers);
        row_start[r]     = start_a;
        row_halt[r]      = halt_a;
        row_nbr[r]       = nbr;
        row_br_pc[r][0]  = b0;
        row_br_tgt[r][0] = t0;
        row_br_pc[r][1]  = b1;
        row_br_tgt[r][1] = t1;
        row_br_pc[r][2]  = b2;
        row_br_tgt[r][2] = t2;
        row_err_en[r]    = e_en;
        row_err[r]       = e_addr;
        row_waits[r]     = waits;
        row_xfers[r]     = xfers;
    endtask

    task automatic fill_memory();
        logic [31:0] seed;
        logic [31:0] w;
        seed = 32'h38ae;
        for (int i = 0; i < MEM_WORDS; i++) begin
            seed = xorshift(seed);
            w    = seed;
            // filler must never look like control flow
            if (w[31:28] == fetch_pkg::OP_BRANCH || w[31:28] == fetch_pkg::OP_HALT) begin
                w[31:28] = 4'h1;
            end
            mem_model_i.mem[i] = w;
        end
    endtask

    task automatic place_row(input int r);
        fetch_pkg::addr_t pc;
        fetch_pkg::addr_t diff;
        fetch_pkg::word_t word;
        for (int b = 0; b < row_nbr[r]; b++) begin
            pc   = row_br_pc[r][b];
            diff = row_br_tgt[r][b] - pc;
            word = mem_model_i.mem[pc[11:2]];
            mem_model_i.mem[pc[11:2]] = {fetch_pkg::OP_BRANCH, word[27:16], diff[17:2]};
        end
        pc   = row_halt[r];
        word = mem_model_i.mem[pc[11:2]];
        mem_model_i.mem[pc[11:2]] = {fetch_pkg::OP_HALT, word[27:0]};
    endtask

    // follows the program through memory to build the expected records
    task automatic walk_row(input int r);
        fetch_pkg::addr_t      pc;
        fetch_pkg::word_t      w;
        fetch_pkg::instr_rec_t rec;
        logic [31:0]           disp;
        logic                  done;
        exp_q.delete();
        pc   = row_start[r];
        done = 1'b0;
        while (!done) begin
            rec        = '0;
            rec.pc     = pc;
            rec.target = pc + 32'd4;
            if (row_err_en[r] && pc[31:3] == row_err[r][31:3]) begin
                rec.fault = 1'b1;
                done      = 1'b1;
            end else begin
                w        = mem_model_i.mem[pc[11:2]];
                rec.word = w;
                if (w[31:28] == fetch_pkg::OP_BRANCH) begin
                    disp          = {{16{w[15]}}, w[15:0]};
                    rec.is_branch = 1'b1;
                    rec.target    = pc + (disp << 2);
                end else if (w[31:28] == fetch_pkg::OP_HALT) begin
                    rec.is_halt = 1'b1;
                    done        = 1'b1;
                end
            end
            exp_q.push_back(rec);
            pc = rec.target;
            if (exp_q.size() >= MAX_WALK) begin
                $display("golden walk of row %0d never reaches a halt", r);
                errors++;
                done = 1'b1;
            end
        end
    endtask

    task automatic check_rec(input string name, input fetch_pkg::instr_rec_t got,
                             input fetch_pkg::instr_rec_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        fetch_pkg::instr_rec_t got_q [$];
        int                    xfer_base;
        int                    err_base;
        walk_row(r);
        err_base    = errors;
        wait_states = row_waits[r];
        err_en      = row_err_en[r];
        err_addr    = row_err[r];
        xfer_base   = xfer_count;
        start_pc    = row_start[r];
        start       = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (busy) begin
            @(posedge clk);
            #1;
            if (out_valid) begin
                got_q.push_back(out_rec);
            end
        end
        check_count("record count", got_q.size(), exp_q.size());
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_addr("out_rec.pc", got_q[i].pc, exp_q[i].pc);
            check_addr("out_rec.target", got_q[i].target, exp_q[i].target);
            check_rec("out_rec", got_q[i], exp_q[i]);
        end
        check_count("apb transfers", xfer_count - xfer_base, row_xfers[r]);
        // the reader stops at the transfer that reports the error
        if (row_err_en[r]) begin
            check_addr("paddr", last_paddr, row_err[r]);
        end
        $display("row %0d start %h: %0d records, %0d transfers, %s", r, row_start[r],
                 got_q.size(), xfer_count - xfer_base,
                 (errors == err_base) ? "ok" : "FAILED");
    endtask

    initial begin
        int limit;
        rst         = 1'b1;
        start       = 1'b0;
        start_pc    = '0;
        wait_states = '0;
        err_en      = 1'b0;
        err_addr    = '0;

        // straight run to a halt, then the same again from a warm cache
        set_row(0, 32'h000, 32'h01c, 0, 0, 0, 0, 0, 0, 0, 1'b0, 0, 4'd0, 8);
        set_row(1, 32'h000, 32'h01c, 0, 0, 0, 0, 0, 0, 0, 1'b0, 0, 4'd0, 0);
        // forward, backward and same-line branches
        set_row(2, 32'h040, 32'h054, 3, 32'h044, 32'h060, 32'h064, 32'h050,
                32'h050, 32'h054, 1'b0, 0, 4'd0, 6);
        // lines 080, 280, 480 share set 16
        set_row(3, 32'h084, 32'h080, 3, 32'h084, 32'h280, 32'h284, 32'h480,
                32'h484, 32'h080, 1'b0, 0, 4'd0, 8);
        set_row(4, 32'h084, 32'h080, 3, 32'h084, 32'h280, 32'h284, 32'h480,
                32'h484, 32'h080, 1'b0, 0, 4'd1, 6);
        set_row(5, 32'h100, 32'h118, 1, 32'h108, 32'h118, 0, 0, 0, 0, 1'b0, 0, 4'd3, 6);
        // error on the upper word of line 148
        set_row(6, 32'h140, 32'h14c, 0, 0, 0, 0, 0, 0, 0, 1'b1, 32'h14c, 4'd1, 4);
        set_row(7, 32'h140, 32'h14c, 0, 0, 0, 0, 0, 0, 0, 1'b0, 0, 4'd2, 2);

        fill_memory();
        for (int r = 0; r < NUM_ROWS; r++) begin
            place_row(r);
        end
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            walk_row(r);
            limit = limit + 40 * exp_q.size();
        end
        cycle_limit = limit;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_count("busy after reset", int'(busy), 0);
        check_count("out_valid after reset", int'(out_valid), 0);
        check_count("psel after reset", int'(psel), 0);
        check_count("penable after reset", int'(penable), 0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== bench/apb_mem_model.sv ====
`timescale 1ns/1ps

module apb_mem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             psel,
    input  logic             penable,
    input  fetch_pkg::addr_t paddr,
    input  logic [3:0]       wait_states,
    input  logic             err_en,
    input  fetch_pkg::addr_t err_addr,
    output logic             pready,
    output fetch_pkg::word_t prdata,
    output logic             pslverr
);

    localparam int DEPTH = 1024;

    // 4 KB of words loaded by the testbench
    fetch_pkg::word_t mem [DEPTH];

    logic [3:0] wait_cnt;

    // counts stalled cycles of the access phase
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (psel && penable && !pready) begin
            wait_cnt <= wait_cnt + 4'd1;
        end else begin
            wait_cnt <= '0;
        end
    end

    assign pready  = psel && penable && (wait_cnt == wait_states);
    assign prdata  = mem[paddr[11:2]];
    assign pslverr = pready && err_en && (paddr[31:2] == err_addr[31:2]);

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter int NUM_SETS   = 64,
    parameter int APB_ADDR_W = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  fetch_pkg::addr_t      start_pc,
    input  logic                  pready,
    input  fetch_pkg::word_t      prdata,
    input  logic                  pslverr,
    output logic                  psel,
    output logic                  penable,
    output logic [APB_ADDR_W-1:0] paddr,
    output logic                  out_valid,
    output fetch_pkg::instr_rec_t out_rec,
    output logic                  busy
);

    logic             req_valid;
    logic             req_ready;
    fetch_pkg::addr_t req_addr;
    logic             resp_valid;
    fetch_pkg::word_t resp_word;
    logic             resp_fault;
    logic             redirect;
    fetch_pkg::addr_t redirect_pc;
    logic             stop;
    logic             line_req;
    fetch_pkg::addr_t line_addr;
    logic             line_done;
    fetch_pkg::line_t line_data;
    logic             line_err;

    fetch_sequencer fetch_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .start_pc    (start_pc),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stop        (stop),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .busy        (busy)
    );

    icache #(
        .NUM_SETS (NUM_SETS)
    ) icache_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .line_done  (line_done),
        .line_data  (line_data),
        .line_err   (line_err),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_word  (resp_word),
        .resp_fault (resp_fault),
        .line_req   (line_req),
        .line_addr  (line_addr)
    );

    apb_line_reader #(
        .APB_ADDR_W (APB_ADDR_W)
    ) apb_line_reader_i (
        .clk       (clk),
        .rst       (rst),
        .line_req  (line_req),
        .line_addr (line_addr),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .line_done (line_done),
        .line_data (line_data),
        .line_err  (line_err),
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr)
    );

    // pc of the response is the request address still held by the sequencer
    instr_predecoder instr_predecoder_i (
        .clk         (clk),
        .rst         (rst),
        .resp_valid  (resp_valid),
        .resp_word   (resp_word),
        .resp_fault  (resp_fault),
        .req_addr    (req_addr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stop        (stop),
        .out_valid   (out_valid),
        .out_rec     (out_rec)
    );

endmodule

// ==== verilog/instr_predecoder.sv ====
`timescale 1ns/1ps

module instr_predecoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  resp_valid,
    input  fetch_pkg::word_t      resp_word,
    input  logic                  resp_fault,
    input  fetch_pkg::addr_t      req_addr,
    output logic                  redirect,
    output fetch_pkg::addr_t      redirect_pc,
    output logic                  stop,
    output logic                  out_valid,
    output fetch_pkg::instr_rec_t out_rec
);

    fetch_pkg::instr_u     word;
    logic                  is_branch;
    logic                  is_halt;
    fetch_pkg::addr_t      br_target;
    fetch_pkg::instr_rec_t rec;

    assign word = resp_word;

    // a faulted word is never taken as control flow
    assign is_branch = !resp_fault && (word.br.opcode == fetch_pkg::OP_BRANCH);
    assign is_halt   = !resp_fault && (word.op.opcode == fetch_pkg::OP_HALT);

    // word displacement that wraps at 32 bits
    assign br_target = req_addr + {{14{word.br.disp[15]}}, word.br.disp, 2'b00};

    assign redirect    = resp_valid && is_branch;
    assign redirect_pc = br_target;
    assign stop        = resp_valid && (is_halt || resp_fault);

    always_comb begin
        rec.pc        = req_addr;
        rec.word      = word;
        rec.is_branch = is_branch;
        rec.is_halt   = is_halt;
        rec.fault     = resp_fault;
        // next pc the sequencer follows
        rec.target    = is_branch ? br_target : req_addr + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_valid) begin
            out_rec <= rec;
        end
    end

endmodule

// ==== icache/apb_line_reader.sv ====
`timescale 1ns/1ps

module apb_line_reader #(
    parameter int APB_ADDR_W = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  line_req,
    input  fetch_pkg::addr_t      line_addr,
    input  logic                  pready,
    input  fetch_pkg::word_t      prdata,
    input  logic                  pslverr,
    output logic                  line_done,
    output fetch_pkg::line_t      line_data,
    output logic                  line_err,
    output logic                  psel,
    output logic                  penable,
    output logic [APB_ADDR_W-1:0] paddr
);

    localparam logic [1:0] R_IDLE   = 2'd0;
    localparam logic [1:0] R_SETUP  = 2'd1;
    localparam logic [1:0] R_ACCESS = 2'd2;

    logic [1:0]       state;
    logic             beat;
    fetch_pkg::addr_t base;
    fetch_pkg::word_t lo_word;
    logic             xfer_end;

    assign xfer_end = (state == R_ACCESS) && pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= R_IDLE;
            beat      <= 1'b0;
            line_done <= 1'b0;
            line_err  <= 1'b0;
        end else begin
            line_done <= 1'b0;
            line_err  <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (line_req) begin
                        beat  <= 1'b0;
                        state <= R_SETUP;
                    end
                end
                R_SETUP: state <= R_ACCESS;
                R_ACCESS: begin
                    if (pready) begin
                        if (pslverr) begin
                            line_err <= 1'b1;
                            state    <= R_IDLE;
                        end else if (!beat) begin
                            beat  <= 1'b1;
                            state <= R_SETUP;
                        end else begin
                            line_done <= 1'b1;
                            state     <= R_IDLE;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && line_req) begin
            base <= line_addr;
        end
        if (xfer_end && !beat) begin
            lo_word <= prdata;
        end
        if (xfer_end && beat) begin
            line_data <= {prdata, lo_word};
        end
    end

    assign psel    = (state != R_IDLE);
    assign penable = (state == R_ACCESS);
    // line address is 8-byte aligned
    assign paddr   = APB_ADDR_W'({base[31:3], beat, 2'b00});

    a_enable_in_select: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel);

endmodule

// ==== icache/icache.sv ====
`timescale 1ns/1ps

module icache #(
    parameter int NUM_SETS = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  fetch_pkg::addr_t req_addr,
    input  logic             line_done,
    input  fetch_pkg::line_t line_data,
    input  logic             line_err,
    output logic             req_ready,
    output logic             resp_valid,
    output fetch_pkg::word_t resp_word,
    output logic             resp_fault,
    output logic             line_req,
    output fetch_pkg::addr_t line_addr
);

    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int TAG_LO = fetch_pkg::OFFSET_W + IDX_W;
    // fewer sets means wider tags
    localparam int TAGS_W = fetch_pkg::TAG_W + fetch_pkg::INDEX_W - IDX_W;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_MISS   = 3'd2;
    localparam logic [2:0] S_REFILL = 3'd3;
    localparam logic [2:0] S_FAULT  = 3'd4;

    logic [2:0]         state;
    logic [2:0]         next_state;

    logic [TAGS_W-1:0]  req_tag;
    logic [IDX_W-1:0]   req_index;
    logic               req_word;

    logic [NUM_SETS-1:0] way_valid [2];
    logic [TAGS_W-1:0]   way_tag   [2][NUM_SETS];
    fetch_pkg::line_t    way_data  [2][NUM_SETS];
    logic [NUM_SETS-1:0] victim;
    fetch_pkg::line_t    refill_line;

    logic [1:0]          hit;
    logic                cache_hit;
    logic                victim_way;
    fetch_pkg::line_t    hit_line;
    fetch_pkg::word_t    hit_word;

    // request buffer
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_tag   <= req_addr[31:TAG_LO];
            req_index <= req_addr[TAG_LO-1:fetch_pkg::OFFSET_W];
            req_word  <= req_addr[2];
        end
    end

    assign hit[0] = way_valid[0][req_index] && (way_tag[0][req_index] == req_tag);
    assign hit[1] = way_valid[1][req_index] && (way_tag[1][req_index] == req_tag);
    assign cache_hit = |hit;
    assign victim_way = victim[req_index];

    assign hit_line = hit[1] ? way_data[1][req_index] : way_data[0][req_index];
    assign hit_word = req_word ? hit_line[63:32] : hit_line[31:0];

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (req_valid) begin
                    next_state = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                next_state = cache_hit ? S_IDLE : S_MISS;
            end
            S_MISS: begin
                if (line_err) begin
                    next_state = S_FAULT;
                end else if (line_done) begin
                    next_state = S_REFILL;
                end
            end
            S_REFILL: next_state = S_LOOKUP;
            S_FAULT:  next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_IDLE;
            way_valid[0] <= '0;
            way_valid[1] <= '0;
            victim       <= '0;
        end else begin
            state <= next_state;
            if (state == S_REFILL) begin
                way_valid[victim_way][req_index] <= 1'b1;
                victim[req_index]                <= !victim_way;
            end
        end
    end

    // missed line waits here for the refill cycle
    always_ff @(posedge clk) begin
        if (state == S_MISS && line_done) begin
            refill_line <= line_data;
        end
        if (state == S_REFILL) begin
            way_tag[victim_way][req_index]  <= req_tag;
            way_data[victim_way][req_index] <= refill_line;
        end
    end

    assign req_ready  = (state == S_IDLE);
    assign resp_valid = (state == S_LOOKUP && cache_hit) || (state == S_FAULT);
    assign resp_fault = (state == S_FAULT);
    assign resp_word  = (state == S_LOOKUP && cache_hit) ? hit_word : '0;

    assign line_req  = (state == S_LOOKUP) && !cache_hit;
    assign line_addr = {req_tag, req_index, {fetch_pkg::OFFSET_W{1'b0}}};

    // refill only fills a way after a miss in both
    a_one_way_hits: assert property (@(posedge clk) disable iff (rst)
        state == S_LOOKUP |-> $onehot0(hit));

endmodule

// ==== verilog/fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fetch_pkg::addr_t start_pc,
    input  logic             req_ready,
    input  logic             resp_valid,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             stop,
    output logic             req_valid,
    output fetch_pkg::addr_t req_addr,
    output logic             busy
);

    fetch_pkg::addr_t pc;
    logic             running;
    logic             stopping;

    // pc only moves on a response, so it still names the returned word
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            running   <= 1'b0;
            stopping  <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            stopping <= resp_valid && stop && running;
            if (start && !busy) begin
                pc        <= start_pc;
                running   <= 1'b1;
                req_valid <= 1'b1;
            end else begin
                if (req_valid && req_ready) begin
                    req_valid <= 1'b0;
                end
                if (resp_valid && running) begin
                    if (stop) begin
                        running <= 1'b0;
                    end else begin
                        pc        <= redirect ? redirect_pc : pc + 32'd4;
                        req_valid <= 1'b1;
                    end
                end
            end
        end
    end

    assign req_addr = pc;

    // stays up through the cycle the last record leaves
    assign busy = running || stopping;

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_addr));

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] line_t;

    // tag above index above byte offset
    // bit 2 picks the word within a line
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;

    localparam logic [3:0] OP_BRANCH = 4'hB;
    localparam logic [3:0] OP_HALT   = 4'hF;

    // branch view with the displacement counted in words
    typedef struct packed {
        logic [3:0]         opcode;
        logic [11:0]        reserved;
        logic signed [15:0] disp;
    } br_fmt_t;

    // plain operation view
    typedef struct packed {
        logic [3:0]  opcode;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [19:0] imm;
    } op_fmt_t;

    // opcode sits in the same bits in both views
    typedef union packed {
        br_fmt_t br;
        op_fmt_t op;
    } instr_u;

    typedef struct packed {
        addr_t  pc;
        instr_u word;
        logic   is_branch;
        logic   is_halt;
        logic   fault;
        addr_t  target;
    } instr_rec_t;

endpackage
